// File: design/tag_pkg.sv
package tag_pkg;

    // ====================================================================
    // sizes
    // ====================================================================
    localparam int LANE_NUM    = 2;
    localparam int WAY_NUM     = 4;
    localparam int INDEX_WIDTH = 4;   // 16 sets
    localparam int TAG_WIDTH   = 8;
    localparam int WAY_WIDTH   = $clog2(WAY_NUM);

    // ====================================================================
    // opcodes and payloads
    // ====================================================================
    typedef enum logic {
        cmd_read  = 1'b0,
        cmd_write = 1'b1
    } cache_op_e;

    typedef struct packed {
        cache_op_e              op;
        logic [INDEX_WIDTH-1:0] index;
        logic [TAG_WIDTH-1:0]   tag;
    } cache_req_t;

    typedef struct packed {
        logic                 valid;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // way 0 in the low bits
    typedef tag_entry_t [WAY_NUM-1:0] tag_set_t;

    typedef struct packed {
        logic                 hit;
        logic [WAY_WIDTH-1:0] way;         // hit way or victim
        logic                 need_evict;
        logic [TAG_WIDTH-1:0] evict_tag;
    } lookup_res_t;

endpackage

// File: design/lane_port_if.sv
`timescale 1ns/1ps

interface lane_port_if
    import tag_pkg::*;
();

    // accepted request, valid in the acceptance cycle
    logic                   acc_vld;
    cache_req_t             acc_req;
    logic [WAY_WIDTH-1:0]   victim_way;

    // refill write, same on every lane
    logic                   ram_wr_en;
    logic [INDEX_WIDTH-1:0] ram_wr_index;
    tag_set_t               ram_wr_set_tag;
    logic                   wbuf_grant;

    // pending refill held by the lane
    logic                   wbuf_vld;
    logic [INDEX_WIDTH-1:0] wbuf_index;
    logic [TAG_WIDTH-1:0]   wbuf_tag;
    logic [WAY_WIDTH-1:0]   wbuf_way;

    modport arb (
        output acc_vld, acc_req, victim_way,
        output ram_wr_en, ram_wr_index, ram_wr_set_tag, wbuf_grant,
        input  wbuf_vld, wbuf_index, wbuf_tag, wbuf_way
    );

    modport lane (
        input  acc_vld, acc_req, victim_way,
        input  ram_wr_en, ram_wr_index, ram_wr_set_tag, wbuf_grant,
        output wbuf_vld, wbuf_index, wbuf_tag, wbuf_way
    );

endinterface

// File: design/lookup_if.sv
`timescale 1ns/1ps

interface lookup_if
    import tag_pkg::*;
();

    logic                   vld;           // result cycle
    cache_op_e              op;
    logic [INDEX_WIDTH-1:0] index;
    logic                   hit;
    logic [WAY_WIDTH-1:0]   dest_way;
    logic                   victim_valid;
    logic [TAG_WIDTH-1:0]   victim_tag;

    modport lane (
        output vld, op, index, hit, dest_way, victim_valid, victim_tag
    );

    modport tracker (
        input  vld, op, index, hit, dest_way, victim_valid, victim_tag
    );

endinterface

// File: design/tag_access_arbiter.sv
`timescale 1ns/1ps

module tag_access_arbiter
    import tag_pkg::*;
#(
    parameter int LANE_NUM = tag_pkg::LANE_NUM
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [LANE_NUM-1:0] req_vld,
    input  cache_req_t          req_pld [LANE_NUM],
    input  tag_set_t            ram_rd_set [LANE_NUM],
    output logic                req_rdy,
    lane_port_if.arb            lanes [LANE_NUM]
);

    logic [LANE_NUM-1:0]    buf_vld;
    logic [LANE_NUM-1:0]    grant;
    logic [INDEX_WIDTH-1:0] buf_index [LANE_NUM];
    logic [TAG_WIDTH-1:0]   buf_tag [LANE_NUM];
    logic [WAY_WIDTH-1:0]   buf_way [LANE_NUM];
    logic                   wr_en;
    logic [INDEX_WIDTH-1:0] wr_index;
    tag_set_t               wr_set;
    logic [WAY_WIDTH-1:0]   victim_q;
    logic                   any_acc;

    // ====================================================================
    // handshake and refill grant
    // ====================================================================
    assign req_rdy = ~|buf_vld;                                  // stall while refills pend
    assign grant   = buf_vld & ~(buf_vld - LANE_NUM'(1));        // lowest lane first
    assign any_acc = req_rdy & (|req_vld);

    // merge the granted tag into that lane's captured set
    always_comb begin
        wr_en    = 1'b0;
        wr_index = '0;
        wr_set   = '0;
        for (int i = 0; i < LANE_NUM; i++) begin
            if (grant[i]) begin
                wr_en                    = 1'b1;
                wr_index                 = buf_index[i];
                wr_set                   = ram_rd_set[i];
                wr_set[buf_way[i]].valid = 1'b1;
                wr_set[buf_way[i]].tag   = buf_tag[i];
            end
        end
    end

    // ====================================================================
    // victim pointer
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= '0;
        end else if (any_acc) begin
            victim_q <= victim_q + WAY_WIDTH'(1);   // once per accepted cycle
        end
    end

    // per lane fan-out
    for (genvar i = 0; i < LANE_NUM; i++) begin : g_lane
        assign buf_vld[i]   = lanes[i].wbuf_vld;
        assign buf_index[i] = lanes[i].wbuf_index;
        assign buf_tag[i]   = lanes[i].wbuf_tag;
        assign buf_way[i]   = lanes[i].wbuf_way;

        assign lanes[i].acc_vld        = req_vld[i] & req_rdy;
        assign lanes[i].acc_req        = req_pld[i];
        assign lanes[i].victim_way     = victim_q;
        assign lanes[i].ram_wr_en      = wr_en;
        assign lanes[i].ram_wr_index   = wr_index;
        assign lanes[i].ram_wr_set_tag = wr_set;
        assign lanes[i].wbuf_grant     = grant[i];
    end

endmodule

// File: design/tag_lookup_lane.sv
`timescale 1ns/1ps

module tag_lookup_lane
    import tag_pkg::*;
#(
    parameter int WAY_NUM     = tag_pkg::WAY_NUM,
    parameter int INDEX_WIDTH = tag_pkg::INDEX_WIDTH
) (
    input  logic      clk,
    input  logic      rst_n,
    lane_port_if.lane port,
    lookup_if.lane    look,
    output tag_set_t  ram_rd_set
);

    localparam int SET_NUM = 2 ** INDEX_WIDTH;

    logic [WAY_NUM-1:0][TAG_WIDTH-1:0] tag_mem [SET_NUM];
    logic [WAY_NUM-1:0]                valid_mem [SET_NUM];
    tag_set_t                          rd_q;

    logic                   req_vld_q;
    cache_req_t             req_q;
    logic [WAY_WIDTH-1:0]   victim_q;

    logic                   wbuf_vld_q;
    logic [INDEX_WIDTH-1:0] wbuf_index_q;
    logic [TAG_WIDTH-1:0]   wbuf_tag_q;
    logic [WAY_WIDTH-1:0]   wbuf_way_q;
    tag_set_t               wbuf_set_q;    // set image the refill is written into

    tag_set_t               eff_set;
    logic [WAY_NUM-1:0]     hit_oh;
    logic [WAY_WIDTH-1:0]   hit_way;
    logic                   hit;
    logic                   miss_load;

    // ====================================================================
    // tag RAM copy
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SET_NUM; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (port.ram_wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_mem[port.ram_wr_index][w] <= port.ram_wr_set_tag[w].valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.ram_wr_en) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                tag_mem[port.ram_wr_index][w] <= port.ram_wr_set_tag[w].tag;
            end
        end
        if (port.acc_vld) begin   // read on the acceptance edge
            for (int w = 0; w < WAY_NUM; w++) begin
                rd_q[w].valid <= valid_mem[port.acc_req.index][w];
                rd_q[w].tag   <= tag_mem[port.acc_req.index][w];
            end
        end
    end

    // request register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld_q <= 1'b0;
        end else begin
            req_vld_q <= port.acc_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (port.acc_vld) begin
            req_q    <= port.acc_req;
            victim_q <= port.victim_way;
        end
    end

    // ====================================================================
    // compare
    // ====================================================================
    // refill data overrides what the RAM returned
    always_comb begin
        eff_set = rd_q;
        if (port.ram_wr_en && port.ram_wr_index == req_q.index) begin
            eff_set = port.ram_wr_set_tag;
        end
        if (wbuf_vld_q && wbuf_index_q == req_q.index) begin
            eff_set[wbuf_way_q].valid = 1'b1;
            eff_set[wbuf_way_q].tag   = wbuf_tag_q;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            hit_oh[w] = eff_set[w].valid && (eff_set[w].tag == req_q.tag);
            if (hit_oh[w]) begin
                hit_way = WAY_WIDTH'(w);
            end
        end
    end

    assign hit       = |hit_oh;
    assign miss_load = req_vld_q & ~hit;

    assign look.vld          = req_vld_q;
    assign look.op           = req_q.op;
    assign look.index        = req_q.index;
    assign look.hit          = hit;
    assign look.dest_way     = hit ? hit_way : victim_q;
    assign look.victim_valid = eff_set[victim_q].valid;
    assign look.victim_tag   = eff_set[victim_q].tag;

    // ====================================================================
    // write-tag buffer
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbuf_vld_q <= 1'b0;
        end else if (miss_load) begin
            wbuf_vld_q <= 1'b1;     // new miss wins over a grant
        end else if (port.wbuf_grant) begin
            wbuf_vld_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_load) begin
            wbuf_index_q <= req_q.index;
            wbuf_tag_q   <= req_q.tag;
            wbuf_way_q   <= victim_q;
            wbuf_set_q   <= eff_set;
        end else if (wbuf_vld_q && port.ram_wr_en && port.ram_wr_index == wbuf_index_q) begin
            wbuf_set_q   <= port.ram_wr_set_tag;   // keep image current
        end
    end

    assign port.wbuf_vld   = wbuf_vld_q;
    assign port.wbuf_index = wbuf_index_q;
    assign port.wbuf_tag   = wbuf_tag_q;
    assign port.wbuf_way   = wbuf_way_q;
    assign ram_rd_set      = wbuf_set_q;

endmodule

// File: design/dirty_tracker.sv
`timescale 1ns/1ps

module dirty_tracker
    import tag_pkg::*;
#(
    parameter int LANE_NUM = tag_pkg::LANE_NUM
) (
    input  logic                clk,
    input  logic                rst_n,
    lookup_if.tracker           looks [LANE_NUM],
    output logic [LANE_NUM-1:0] res_vld,
    output lookup_res_t         res_pld [LANE_NUM]
);

    localparam int SET_NUM = 2 ** INDEX_WIDTH;

    logic [WAY_NUM-1:0]     dirty_q [SET_NUM];
    logic [LANE_NUM-1:0]    wr_en;
    logic [LANE_NUM-1:0]    wr_bit;
    logic [INDEX_WIDTH-1:0] wr_index [LANE_NUM];
    logic [WAY_WIDTH-1:0]   wr_way [LANE_NUM];

    // ====================================================================
    // per lane decode and result
    // ====================================================================
    for (genvar i = 0; i < LANE_NUM; i++) begin : g_port
        logic is_write;
        logic miss;
        logic old_dirty;

        assign is_write  = (looks[i].op == cmd_write);
        assign miss      = ~looks[i].hit;
        assign old_dirty = dirty_q[looks[i].index][looks[i].dest_way];  // before update

        // write sets, read miss clears, read hit leaves it
        assign wr_en[i]    = looks[i].vld & (is_write | miss);
        assign wr_bit[i]   = is_write;
        assign wr_index[i] = looks[i].index;
        assign wr_way[i]   = looks[i].dest_way;

        assign res_vld[i] = looks[i].vld;
        assign res_pld[i] = '{
            hit:        looks[i].hit,
            way:        looks[i].dest_way,
            need_evict: miss & looks[i].victim_valid & old_dirty,
            evict_tag:  looks[i].victim_tag
        };
    end

    // ====================================================================
    // dirty array, one write port per lane
    // ====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SET_NUM; s++) begin
                dirty_q[s] <= '0;
            end
        end else begin
            for (int i = 0; i < LANE_NUM; i++) begin
                if (wr_en[i]) begin
                    dirty_q[wr_index[i]][wr_way[i]] <= wr_bit[i];
                end
            end
        end
    end

endmodule

// File: design/tag_ctrl_top.sv
`timescale 1ns/1ps

module tag_ctrl_top
    import tag_pkg::*;
#(
    parameter int WAY_NUM     = tag_pkg::WAY_NUM,
    parameter int INDEX_WIDTH = tag_pkg::INDEX_WIDTH
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [LANE_NUM-1:0] req_vld,
    input  cache_req_t          req_pld [LANE_NUM],
    output logic                req_rdy,
    output logic [LANE_NUM-1:0] res_vld,
    output lookup_res_t         res_pld [LANE_NUM]
);

    lane_port_if lane_ports [LANE_NUM] ();
    lookup_if    looks [LANE_NUM] ();
    tag_set_t    lane_rd_set [LANE_NUM];   // refill set images

    // ====================================================================
    // access control
    // ====================================================================
    tag_access_arbiter #(
        .LANE_NUM   (LANE_NUM)
    ) u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_vld    (req_vld),
        .req_pld    (req_pld),
        .ram_rd_set (lane_rd_set),
        .req_rdy    (req_rdy),
        .lanes      (lane_ports)
    );

    // one tag RAM copy per lane
    for (genvar i = 0; i < LANE_NUM; i++) begin : g_lane
        tag_lookup_lane #(
            .WAY_NUM     (WAY_NUM),
            .INDEX_WIDTH (INDEX_WIDTH)
        ) u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .port        (lane_ports[i]),
            .look        (looks[i]),
            .ram_rd_set  (lane_rd_set[i])
        );
    end

    // ====================================================================
    // dirty state and results
    // ====================================================================
    dirty_tracker #(
        .LANE_NUM   (LANE_NUM)
    ) u_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .looks      (looks),
        .res_vld    (res_vld),
        .res_pld    (res_pld)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verification/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
    import tag_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [LANE_NUM-1:0] req_vld,
    input  cache_req_t          req_pld [LANE_NUM],
    input  logic                req_rdy,
    input  logic [LANE_NUM-1:0] exp_hit,
    input  logic [LANE_NUM-1:0] exp_evict,
    input  logic [LANE_NUM-1:0] res_vld,
    input  lookup_res_t         res_pld [LANE_NUM],
    output int                  test_count,
    output int                  error_count
);

    localparam int SET_NUM = 2 ** INDEX_WIDTH;

    // reference state of the cache tags
    logic [WAY_NUM-1:0]                m_valid [SET_NUM];
    logic [WAY_NUM-1:0]                m_dirty [SET_NUM];
    logic [WAY_NUM-1:0][TAG_WIDTH-1:0] m_tag [SET_NUM];
    int                                victim;

    // one outstanding result per lane
    logic                 pend [LANE_NUM];
    cache_req_t           e_req [LANE_NUM];
    logic                 e_hit [LANE_NUM];
    logic [WAY_WIDTH-1:0] e_way [LANE_NUM];
    logic                 e_evict [LANE_NUM];
    logic [TAG_WIDTH-1:0] e_etag [LANE_NUM];

    task automatic compare_field(input int lane, input string field,
                                 input logic [TAG_WIDTH-1:0] exp_v,
                                 input logic [TAG_WIDTH-1:0] got_v, inout logic bad);
        if (got_v !== exp_v) begin
            $display("[FAIL] t=%0t res_pld[%0d].%s expected %0h got %0h",
                     $time, lane, field, exp_v, got_v);
            error_count++;
            bad = 1'b1;
        end
    endtask

    // ====================================================================
    // reference model, one lookup
    // ====================================================================
    task automatic predict(input int lane);
        cache_req_t           r;
        logic                 hit;
        logic [WAY_WIDTH-1:0] dw;
        logic                 ev;
        r   = req_pld[lane];
        hit = 1'b0;
        dw  = WAY_WIDTH'(victim);
        for (int w = 0; w < WAY_NUM; w++) begin
            if (m_valid[r.index][w] && m_tag[r.index][w] == r.tag) begin
                hit = 1'b1;
                dw  = WAY_WIDTH'(w);
            end
        end
        ev = !hit && m_valid[r.index][dw] && m_dirty[r.index][dw];   // old dirty bit
        e_req[lane]   = r;
        e_hit[lane]   = hit;
        e_way[lane]   = dw;
        e_evict[lane] = ev;
        e_etag[lane]  = m_tag[r.index][dw];
        pend[lane]    = 1'b1;
        if (!hit) begin
            m_valid[r.index][dw] = 1'b1;
            m_tag[r.index][dw]   = r.tag;
        end
        if (r.op == cmd_write) begin
            m_dirty[r.index][dw] = 1'b1;
        end else if (!hit) begin
            m_dirty[r.index][dw] = 1'b0;
        end
        if (exp_hit[lane] !== hit || exp_evict[lane] !== ev) begin
            $display("stimulus on lane %0d expects hit %0d need_evict %0d but the model gives %0d %0d",
                     lane, exp_hit[lane], exp_evict[lane], hit, ev);
            error_count++;
        end
    endtask

    task automatic check_result(input int lane);
        logic bad;
        bad = 1'b0;
        if (pend[lane]) begin
            pend[lane] = 1'b0;
            test_count++;
            if (res_vld[lane] !== 1'b1) begin
                $display("lane %0d gave no result in the cycle after acceptance", lane);
                error_count++;
                bad = 1'b1;
            end else begin
                compare_field(lane, "hit", e_hit[lane], res_pld[lane].hit, bad);
                compare_field(lane, "way", e_way[lane], res_pld[lane].way, bad);
                compare_field(lane, "need_evict", e_evict[lane], res_pld[lane].need_evict, bad);
                if (e_evict[lane]) begin
                    compare_field(lane, "evict_tag", e_etag[lane], res_pld[lane].evict_tag, bad);
                end
            end
            $display("test %0d lane %0d %s index %h tag %h: %s", test_count, lane,
                     e_req[lane].op.name(), e_req[lane].index, e_req[lane].tag,
                     bad ? "mismatch" : "ok");
        end else if (res_vld[lane] === 1'b1) begin
            $display("lane %0d produced a result without an accepted request", lane);
            error_count++;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SET_NUM; s++) begin
                m_valid[s] = '0;
                m_dirty[s] = '0;
                m_tag[s]   = '0;
            end
            for (int i = 0; i < LANE_NUM; i++) begin
                pend[i] = 1'b0;
            end
            victim      = 0;
            test_count  = 0;
            error_count = 0;
        end else begin
            for (int i = 0; i < LANE_NUM; i++) begin
                check_result(i);
            end
            if (req_rdy && |req_vld) begin
                for (int i = 0; i < LANE_NUM; i++) begin
                    if (req_vld[i]) begin
                        predict(i);
                    end
                end
                victim = (victim + 1) % WAY_NUM;    // once per accepted cycle
            end
        end
    end

endmodule

// File: verification/tag_ctrl_assert.sv
`timescale 1ns/1ps

module tag_ctrl_assert
    import tag_pkg::*;
(
    input logic                clk,
    input logic                rst_n,
    input logic [LANE_NUM-1:0] req_vld,
    input logic                req_rdy,
    input logic [LANE_NUM-1:0] res_vld,
    input lookup_res_t         res_pld [LANE_NUM]
);

    logic [LANE_NUM-1:0] miss_vld;

    for (genvar i = 0; i < LANE_NUM; i++) begin : g_lane
        assign miss_vld[i] = res_vld[i] & ~res_pld[i].hit;

        a_res_after_acc: assert property (@(posedge clk) disable iff (!rst_n)
            (req_vld[i] && req_rdy) |=> res_vld[i])
            else $error("lane %0d result missing after acceptance", i);

        a_no_stray_res: assert property (@(posedge clk) disable iff (!rst_n)
            !(req_vld[i] && req_rdy) |=> !res_vld[i])
            else $error("lane %0d result without acceptance", i);

        // a miss loads the write-tag buffer
        a_stall_on_refill: assert property (@(posedge clk) disable iff (!rst_n)
            miss_vld[i] |=> !req_rdy)
            else $error("lane %0d req_rdy high with a refill pending", i);
    end

    // no stall without a refill behind it
    a_stall_needs_miss: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req_rdy) |-> $past(|miss_vld))
        else $error("req_rdy dropped without a miss in the cycle before");

endmodule

bind tag_ctrl_top tag_ctrl_assert u_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_rdy (req_rdy),
    .res_vld (res_vld),
    .res_pld (res_pld)
);

// File: verification/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import tag_pkg::*;
();

    localparam int MAX_LINES = 64;

    logic                clk;
    logic                rst_n;
    logic [LANE_NUM-1:0] req_vld;
    cache_req_t          req_pld [LANE_NUM];
    logic                req_rdy;
    logic [LANE_NUM-1:0] res_vld;
    lookup_res_t         res_pld [LANE_NUM];
    logic [LANE_NUM-1:0] exp_hit;
    logic [LANE_NUM-1:0] exp_evict;
    int                  test_count;
    int                  error_count;

    logic [27:0] stim [2*MAX_LINES];   // lane 0 word, lane 1 word per line
    int          n_lines;
    int          n_req;
    logic        loaded;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tag_ctrl_top #(
        .WAY_NUM     (WAY_NUM),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req_pld (req_pld),
        .req_rdy (req_rdy),
        .res_vld (res_vld),
        .res_pld (res_pld)
    );

    tb_checker u_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_vld     (req_vld),
        .req_pld     (req_pld),
        .req_rdy     (req_rdy),
        .exp_hit     (exp_hit),
        .exp_evict   (exp_evict),
        .res_vld     (res_vld),
        .res_pld     (res_pld),
        .test_count  (test_count),
        .error_count (error_count)
    );

    // word layout V O I TT H E, one hex digit each except the tag
    task automatic drive_lane(input int lane, input logic [27:0] w);
        req_vld[lane]       = w[24];
        req_pld[lane].op    = cache_op_e'(w[20]);
        req_pld[lane].index = w[19:16];
        req_pld[lane].tag   = w[15:8];
        exp_hit[lane]       = w[4];
        exp_evict[lane]     = w[0];
    endtask

    // ====================================================================
    // stimulus
    // ====================================================================
    initial begin
        int gap;
        void'($urandom(11));
        req_vld   = '0;
        exp_hit   = '0;
        exp_evict = '0;
        loaded    = 1'b0;
        n_lines   = 0;
        n_req     = 0;
        for (int i = 0; i < LANE_NUM; i++) begin
            req_pld[i] = '0;
        end
        for (int i = 0; i < 2 * MAX_LINES; i++) begin
            stim[i] = '1;   // end marker
        end
        $readmemh("verification/tag_stimulus.txt", stim);
        while (n_lines < MAX_LINES && stim[2*n_lines] != '1) begin
            n_req += int'(stim[2*n_lines][24]) + int'(stim[2*n_lines+1][24]);
            n_lines++;
        end
        loaded = 1'b1;

        wait (rst_n === 1'b1);
        @(negedge clk);
        for (int k = 0; k < n_lines; k++) begin
            gap = $urandom % 3;
            repeat (gap) @(negedge clk);
            drive_lane(0, stim[2*k]);
            drive_lane(1, stim[2*k+1]);
            while (!req_rdy) @(negedge clk);   // hold through the stall
            @(negedge clk);
            req_vld = '0;
        end

        wait (test_count == n_req);
        @(negedge clk);
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded === 1'b1);
        repeat (n_lines * 6 + 20 + 3) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", n_lines * 6 + 23);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: verification/tag_stimulus.txt
// per line: lane 0 word then lane 1 word, digits V O I TT H E
// V valid, O 1 for write, I index, TT tag, H expected hit, E expected need_evict
101a100 102b200
111a110 112b210
101c100 0000000
103d300 101c110
101e101 102f201
101e110 102f210
1144400 0000000
1055500 1044410
1044500 1055510
1111100 1066600
101c110 1066610
1011200 1077700
1011300 0000000
0000000 1011401
1011410 0000000
1155600 112f210
1022201 1055610
1055700 1188800
1099900 1088810
1099910 1055610
1055800 0000000
0000000 1055900
1055a00 0000000
0000000 1055b01

// File: sim.f
design/tag_pkg.sv
design/lane_port_if.sv
design/lookup_if.sv
design/tag_access_arbiter.sv
design/tag_lookup_lane.sv
design/dirty_tracker.sv
design/tag_ctrl_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/tag_ctrl_assert.sv
verification/tb_top.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
    -f sim.f -Mdir obj_dir || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
